/* alu.sv */
// rv64i alu, arithmetic, logic, shifts, word ops and branch compares
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire rv_pkg::alu_op_e         op,
	input  wire logic [rv_pkg::XLEN-1:0] a,
	input  wire logic [rv_pkg::XLEN-1:0] b,
	output logic [rv_pkg::XLEN-1:0]      result,
	output logic                         taken
);

	logic [rv_pkg::XLEN-1:0] sum;
	logic [31:0] word;
	logic word_op;
	logic lt;
	logic ltu;

	assign sum = a + b;
	assign lt  = $signed(a) < $signed(b);
	assign ltu = a < b;

	always_comb begin
		result = sum;
		taken = 1'b0;
		word = '0;
		word_op = 1'b0;
		case (op)
		rv_pkg::ALU_ADD:    result = sum;
		rv_pkg::ALU_SUB:    result = a - b;
		rv_pkg::ALU_SLL:    result = a << b[5:0];
		rv_pkg::ALU_SLT:    result = {{(rv_pkg::XLEN-1){1'b0}}, lt};
		rv_pkg::ALU_SLTU:   result = {{(rv_pkg::XLEN-1){1'b0}}, ltu};
		rv_pkg::ALU_XOR:    result = a ^ b;
		rv_pkg::ALU_SRL:    result = a >> b[5:0];
		rv_pkg::ALU_SRA:    result = $signed(a) >>> b[5:0];
		rv_pkg::ALU_OR:     result = a | b;
		rv_pkg::ALU_AND:    result = a & b;
		rv_pkg::ALU_PASS_B: result = b;
		rv_pkg::ALU_ADDW: begin
			word = a[31:0] + b[31:0];
			word_op = 1'b1;
		end
		rv_pkg::ALU_SUBW: begin
			word = a[31:0] - b[31:0];
			word_op = 1'b1;
		end
		rv_pkg::ALU_SLLW: begin
			word = a[31:0] << b[4:0];
			word_op = 1'b1;
		end
		rv_pkg::ALU_SRLW: begin
			word = a[31:0] >> b[4:0];
			word_op = 1'b1;
		end
		rv_pkg::ALU_SRAW: begin
			word = $signed(a[31:0]) >>> b[4:0];
			word_op = 1'b1;
		end
		rv_pkg::ALU_BEQ:    taken = (a == b);
		rv_pkg::ALU_BNE:    taken = (a != b);
		rv_pkg::ALU_BLT:    taken = lt;
		rv_pkg::ALU_BGE:    taken = ~lt;
		rv_pkg::ALU_BLTU:   taken = ltu;
		rv_pkg::ALU_BGEU:   taken = ~ltu;
		default:            result = sum;
		endcase
		if (word_op) begin
			result = {{(rv_pkg::XLEN-32){word[31]}}, word}; // sign-extend word result
		end
	end

endmodule

`default_nettype wire

/* core_top.sv */
// rv64i execute slice top, operand and write-back muxes, retire report
`timescale 1ns/1ps
`default_nettype none

module core_top (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        inst_valid,
	input  wire logic [31:0] inst,
	output logic             retire_valid,
	output rv_pkg::retire_t  retire,
	output logic [rv_pkg::XLEN-1:0] pc
);

	rv_pkg::decode_ctrl_t ctrl;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [4:0]  rd_addr;
	logic [11:0] csr_addr;
	logic [rv_pkg::XLEN-1:0] imm;
	logic [rv_pkg::XLEN-1:0] rf_rdata1;
	logic [rv_pkg::XLEN-1:0] rf_rdata2;
	logic [rv_pkg::XLEN-1:0] rs1_data;
	logic [rv_pkg::XLEN-1:0] rs2_data;
	logic [rv_pkg::XLEN-1:0] op_a;
	logic [rv_pkg::XLEN-1:0] op_b;
	logic [rv_pkg::XLEN-1:0] alu_result;
	logic [rv_pkg::XLEN-1:0] jalr_sum;
	logic [rv_pkg::XLEN-1:0] csr_rdata;
	logic [rv_pkg::XLEN-1:0] wb_data;
	logic alu_taken;
	logic is_csr;
	logic rf_we;
	logic csr_we;

	id_stage i_id (.inst, .rs1_addr, .rs2_addr, .rd_addr, .imm, .csr_addr, .ctrl);

	regfile i_rf (.clk, .reset, .we(rf_we), .waddr(rd_addr), .raddr1(rs1_addr),
		.raddr2(rs2_addr), .wdata(wb_data), .rdata1(rf_rdata1), .rdata2(rf_rdata2));

	assign rs1_data = ctrl.rs1_ren ? rf_rdata1 : '0;
	assign rs2_data = ctrl.rs2_ren ? rf_rdata2 : '0;
	assign is_csr = (ctrl.csr_op != rv_pkg::CSR_NONE);

	assign op_a = ctrl.op1_pc ? pc : rs1_data;

	always_comb begin
		if (is_csr) begin
			op_b = ctrl.csr_imm ? {{(rv_pkg::XLEN-5){1'b0}}, rs1_addr} : rs1_data; // uimm
		end else begin
			case (ctrl.op2_src)
			rv_pkg::OP2_IMM:  op_b = imm;
			rv_pkg::OP2_FOUR: op_b = rv_pkg::XLEN'(4);
			default:          op_b = rs2_data;
			endcase
		end
	end

	alu i_alu (.op(ctrl.alu_op), .a(op_a), .b(op_b), .result(alu_result), .taken(alu_taken));

	assign jalr_sum = rs1_data + imm; // alu is busy with the link value

	csr_file i_csr (.clk, .reset, .wen(csr_we), .addr(csr_addr), .op(ctrl.csr_op),
		.src(alu_result), .rdata(csr_rdata));

	pc_unit i_pc (.clk, .reset, .advance(inst_valid), .branch(ctrl.branch), .taken(alu_taken),
		.jump(ctrl.jump), .jalr(ctrl.jalr), .imm, .alu_sum(jalr_sum), .pc);

	assign wb_data = is_csr ? (ctrl.csr_ren ? csr_rdata : '0) : alu_result;
	assign rf_we   = inst_valid & ctrl.rd_wen & ~ctrl.illegal;
	assign csr_we  = inst_valid & ctrl.csr_wen & ~ctrl.illegal;

	always_ff @(posedge clk) begin
		if (reset) begin
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= inst_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_valid) begin
			retire.pc <= pc; // pc before this edge's update
			retire.rd <= rd_addr;
			retire.we <= ctrl.rd_wen & ~ctrl.illegal;
			retire.data <= wb_data;
			retire.illegal <= ctrl.illegal;
		end
	end

endmodule

`default_nettype wire

/* csr_file.sv */
// machine csr file with mscratch, mtvec and mepc
`timescale 1ns/1ps
`default_nettype none

module csr_file (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    wen,
	input  wire logic [11:0]             addr,
	input  wire rv_pkg::csr_op_e         op,
	input  wire logic [rv_pkg::XLEN-1:0] src,
	output logic [rv_pkg::XLEN-1:0]      rdata
);

	logic [rv_pkg::XLEN-1:0] mscratch;
	logic [rv_pkg::XLEN-1:0] mtvec;
	logic [rv_pkg::XLEN-1:0] mepc;
	logic [rv_pkg::XLEN-1:0] wdata;

	always_comb begin
		case (addr)
		rv_pkg::CSR_MSCRATCH: rdata = mscratch;
		rv_pkg::CSR_MTVEC:    rdata = mtvec;
		rv_pkg::CSR_MEPC:     rdata = mepc;
		default:              rdata = '0; // unimplemented reads zero
		endcase
	end

	always_comb begin
		case (op)
		rv_pkg::CSR_RW: wdata = src;
		rv_pkg::CSR_RS: wdata = rdata | src;
		rv_pkg::CSR_RC: wdata = rdata & ~src;
		default:        wdata = rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mscratch <= '0;
			mtvec <= '0;
			mepc <= '0;
		end else if (wen) begin
			case (addr)
			rv_pkg::CSR_MSCRATCH: mscratch <= wdata;
			rv_pkg::CSR_MTVEC:    mtvec <= {wdata[rv_pkg::XLEN-1:2], 2'b00}; // direct mode only
			rv_pkg::CSR_MEPC:     mepc <= {wdata[rv_pkg::XLEN-1:1], 1'b0};
			default:              mscratch <= mscratch;
			endcase
		end
	end

	a_mtvec_aligned: assert property (@(posedge clk) disable iff (reset)
		mtvec[1:0] == 2'b00);

endmodule

`default_nettype wire

/* id_stage.sv */
// instruction decoder, register fields, immediates and control bundle
`timescale 1ns/1ps
`default_nettype none

module id_stage (
	input  wire logic [31:0]            inst,
	output logic [4:0]                  rs1_addr,
	output logic [4:0]                  rs2_addr,
	output logic [4:0]                  rd_addr,
	output logic [rv_pkg::XLEN-1:0]     imm,
	output logic [11:0]                 csr_addr,
	output rv_pkg::decode_ctrl_t        ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rv_pkg::XLEN-1:0] imm_i;
	logic [rv_pkg::XLEN-1:0] imm_b;
	logic [rv_pkg::XLEN-1:0] imm_u;
	logic [rv_pkg::XLEN-1:0] imm_j;
	logic ill;

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rd_addr  = inst[11:7];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];
	assign csr_addr = inst[31:20];

	assign imm_i = {{(rv_pkg::XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_b = {{(rv_pkg::XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {{(rv_pkg::XLEN-32){inst[31]}}, inst[31:12], 12'b0};
	assign imm_j = {{(rv_pkg::XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = rv_pkg::ALU_ADD;
		ctrl.op2_src = rv_pkg::OP2_REG;
		ctrl.csr_op = rv_pkg::CSR_NONE;
		imm = '0;
		ill = 1'b0;
		case (opcode)
		rv_pkg::OPC_LUI: begin
			ctrl.rd_wen = 1'b1;
			ctrl.alu_op = rv_pkg::ALU_PASS_B;
			ctrl.op2_src = rv_pkg::OP2_IMM;
			imm = imm_u;
		end
		rv_pkg::OPC_AUIPC: begin
			ctrl.rd_wen = 1'b1;
			ctrl.op1_pc = 1'b1;
			ctrl.op2_src = rv_pkg::OP2_IMM;
			imm = imm_u;
		end
		rv_pkg::OPC_JAL: begin
			ctrl.rd_wen = 1'b1;
			ctrl.op1_pc = 1'b1; // link value pc+4 from the alu
			ctrl.op2_src = rv_pkg::OP2_FOUR;
			ctrl.jump = 1'b1;
			imm = imm_j;
		end
		rv_pkg::OPC_JALR: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rd_wen = 1'b1;
			ctrl.op1_pc = 1'b1;
			ctrl.op2_src = rv_pkg::OP2_FOUR;
			ctrl.jump = 1'b1;
			ctrl.jalr = 1'b1;
			imm = imm_i;
			ill = (funct3 != rv_pkg::F3_ADD);
		end
		rv_pkg::OPC_BRANCH: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rs2_ren = 1'b1;
			ctrl.branch = 1'b1;
			imm = imm_b;
			case (funct3)
			rv_pkg::F3_BEQ:  ctrl.alu_op = rv_pkg::ALU_BEQ;
			rv_pkg::F3_BNE:  ctrl.alu_op = rv_pkg::ALU_BNE;
			rv_pkg::F3_BLT:  ctrl.alu_op = rv_pkg::ALU_BLT;
			rv_pkg::F3_BGE:  ctrl.alu_op = rv_pkg::ALU_BGE;
			rv_pkg::F3_BLTU: ctrl.alu_op = rv_pkg::ALU_BLTU;
			rv_pkg::F3_BGEU: ctrl.alu_op = rv_pkg::ALU_BGEU;
			default:         ill = 1'b1;
			endcase
		end
		rv_pkg::OPC_IMM: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rd_wen = 1'b1;
			ctrl.op2_src = rv_pkg::OP2_IMM;
			imm = imm_i;
			case (funct3)
			rv_pkg::F3_ADD:  ctrl.alu_op = rv_pkg::ALU_ADD;
			rv_pkg::F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
			rv_pkg::F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
			rv_pkg::F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
			rv_pkg::F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
			rv_pkg::F3_AND:  ctrl.alu_op = rv_pkg::ALU_AND;
			rv_pkg::F3_SLL: begin
				ctrl.alu_op = rv_pkg::ALU_SLL;
				ill = (inst[31:26] != 6'h00); // 6-bit shamt
			end
			default: begin
				ctrl.alu_op = inst[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
				ill = (inst[31:26] != 6'h00) && (inst[31:26] != 6'h10);
			end
			endcase
		end
		rv_pkg::OPC_IMM32: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rd_wen = 1'b1;
			ctrl.op2_src = rv_pkg::OP2_IMM;
			imm = imm_i;
			case (funct3)
			rv_pkg::F3_ADD: ctrl.alu_op = rv_pkg::ALU_ADDW;
			rv_pkg::F3_SLL: begin
				ctrl.alu_op = rv_pkg::ALU_SLLW;
				ill = (funct7 != 7'h00);
			end
			rv_pkg::F3_SR: begin
				ctrl.alu_op = inst[30] ? rv_pkg::ALU_SRAW : rv_pkg::ALU_SRLW;
				ill = (funct7 != 7'h00) && (funct7 != 7'h20);
			end
			default: ill = 1'b1;
			endcase
		end
		rv_pkg::OPC_OP: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rs2_ren = 1'b1;
			ctrl.rd_wen = 1'b1;
			if (funct7 == 7'h00) begin
				case (funct3)
				rv_pkg::F3_ADD:  ctrl.alu_op = rv_pkg::ALU_ADD;
				rv_pkg::F3_SLL:  ctrl.alu_op = rv_pkg::ALU_SLL;
				rv_pkg::F3_SLT:  ctrl.alu_op = rv_pkg::ALU_SLT;
				rv_pkg::F3_SLTU: ctrl.alu_op = rv_pkg::ALU_SLTU;
				rv_pkg::F3_XOR:  ctrl.alu_op = rv_pkg::ALU_XOR;
				rv_pkg::F3_SR:   ctrl.alu_op = rv_pkg::ALU_SRL;
				rv_pkg::F3_OR:   ctrl.alu_op = rv_pkg::ALU_OR;
				default:         ctrl.alu_op = rv_pkg::ALU_AND;
				endcase
			end else if (funct7 == 7'h20 && funct3 == rv_pkg::F3_ADD) begin
				ctrl.alu_op = rv_pkg::ALU_SUB;
			end else if (funct7 == 7'h20 && funct3 == rv_pkg::F3_SR) begin
				ctrl.alu_op = rv_pkg::ALU_SRA;
			end else begin
				ill = 1'b1;
			end
		end
		rv_pkg::OPC_OP32: begin
			ctrl.rs1_ren = 1'b1;
			ctrl.rs2_ren = 1'b1;
			ctrl.rd_wen = 1'b1;
			case ({funct7, funct3})
			{7'h00, rv_pkg::F3_ADD}: ctrl.alu_op = rv_pkg::ALU_ADDW;
			{7'h20, rv_pkg::F3_ADD}: ctrl.alu_op = rv_pkg::ALU_SUBW;
			{7'h00, rv_pkg::F3_SLL}: ctrl.alu_op = rv_pkg::ALU_SLLW;
			{7'h00, rv_pkg::F3_SR}:  ctrl.alu_op = rv_pkg::ALU_SRLW;
			{7'h20, rv_pkg::F3_SR}:  ctrl.alu_op = rv_pkg::ALU_SRAW;
			default:                 ill = 1'b1;
			endcase
		end
		rv_pkg::OPC_SYSTEM: begin
			ctrl.rd_wen = 1'b1;
			ctrl.alu_op = rv_pkg::ALU_PASS_B; // rs1 or uimm through to csr_file
			ctrl.csr_imm = funct3[2];
			ctrl.rs1_ren = ~funct3[2];
			case (funct3)
			rv_pkg::F3_CSRRW, rv_pkg::F3_CSRRWI: begin
				ctrl.csr_op = rv_pkg::CSR_RW;
				ctrl.csr_ren = (rd_addr != 5'd0);
				ctrl.csr_wen = 1'b1;
			end
			rv_pkg::F3_CSRRS, rv_pkg::F3_CSRRSI: begin
				ctrl.csr_op = rv_pkg::CSR_RS;
				ctrl.csr_ren = 1'b1;
				ctrl.csr_wen = (rs1_addr != 5'd0);
			end
			rv_pkg::F3_CSRRC, rv_pkg::F3_CSRRCI: begin
				ctrl.csr_op = rv_pkg::CSR_RC;
				ctrl.csr_ren = 1'b1;
				ctrl.csr_wen = (rs1_addr != 5'd0);
			end
			default: ill = 1'b1; // ecall, ebreak and friends
			endcase
		end
		default: ill = 1'b1; // includes load and store
		endcase
		if (ill) begin
			ctrl = '0;
			ctrl.illegal = 1'b1;
		end
	end

	a_alu_op_known: assert property (@(inst)
		!$isunknown(inst) |-> !$isunknown(ctrl.alu_op));

endmodule

`default_nettype wire

/* pc_unit.sv */
// program counter and next-pc select for branch, jal and jalr
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    advance,
	input  wire logic                    branch,
	input  wire logic                    taken,
	input  wire logic                    jump,
	input  wire logic                    jalr,
	input  wire logic [rv_pkg::XLEN-1:0] imm,
	input  wire logic [rv_pkg::XLEN-1:0] alu_sum,
	output logic [rv_pkg::XLEN-1:0]      pc
);

	logic [rv_pkg::XLEN-1:0] next_pc;

	always_comb begin
		if (jalr) begin
			next_pc = {alu_sum[rv_pkg::XLEN-1:1], 1'b0};
		end else if (jump || (branch && taken)) begin
			next_pc = pc + imm;
		end else begin
			next_pc = pc + rv_pkg::XLEN'(4);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (advance) begin
			pc <= next_pc;
		end
	end

	a_pc_even: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0);

endmodule

`default_nettype wire

/* regfile.sv */
// integer register file, two async read ports, one sync write port
`timescale 1ns/1ps
`default_nettype none

module regfile (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    we,
	input  wire logic [4:0]              waddr,
	input  wire logic [4:0]              raddr1,
	input  wire logic [4:0]              raddr2,
	input  wire logic [rv_pkg::XLEN-1:0] wdata,
	output logic [rv_pkg::XLEN-1:0]      rdata1,
	output logic [rv_pkg::XLEN-1:0]      rdata2
);

	logic [rv_pkg::XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin // x0 never written
			regs[waddr] <= wdata;
		end
	end

	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// x0 stays zero over time since writes skip it
	a_x0_port1: assert property (@(posedge clk) disable iff (reset)
		raddr1 == 5'd0 |-> rdata1 == '0);
	a_x0_port2: assert property (@(posedge clk) disable iff (reset)
		raddr2 == 5'd0 |-> rdata2 == '0);

endmodule

`default_nettype wire

/* rv_pkg.sv */
// rv64i execute slice shared types, opcode and csr constants
`default_nettype none

package rv_pkg;

	localparam int XLEN = 64;

	// major opcodes kept by this slice
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_IMM32  = 7'b0011011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP32   = 7'b0111011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD  = 3'd0; // also addi, jalr
	localparam logic [2:0] F3_SLL  = 3'd1;
	localparam logic [2:0] F3_SLT  = 3'd2;
	localparam logic [2:0] F3_SLTU = 3'd3;
	localparam logic [2:0] F3_XOR  = 3'd4;
	localparam logic [2:0] F3_SR   = 3'd5; // srl and sra
	localparam logic [2:0] F3_OR   = 3'd6;
	localparam logic [2:0] F3_AND  = 3'd7;

	localparam logic [2:0] F3_BEQ  = 3'd0;
	localparam logic [2:0] F3_BNE  = 3'd1;
	localparam logic [2:0] F3_BLT  = 3'd4;
	localparam logic [2:0] F3_BGE  = 3'd5;
	localparam logic [2:0] F3_BLTU = 3'd6;
	localparam logic [2:0] F3_BGEU = 3'd7;

	localparam logic [2:0] F3_CSRRW  = 3'd1;
	localparam logic [2:0] F3_CSRRS  = 3'd2;
	localparam logic [2:0] F3_CSRRC  = 3'd3;
	localparam logic [2:0] F3_CSRRWI = 3'd5;
	localparam logic [2:0] F3_CSRRSI = 3'd6;
	localparam logic [2:0] F3_CSRRCI = 3'd7;

	localparam logic [11:0] CSR_MSCRATCH = 12'h340;
	localparam logic [11:0] CSR_MTVEC    = 12'h305;
	localparam logic [11:0] CSR_MEPC     = 12'h341;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B,
		ALU_ADDW, ALU_SUBW, ALU_SLLW, ALU_SRLW, ALU_SRAW,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} alu_op_e;

	typedef enum logic [1:0] {OP2_REG, OP2_IMM, OP2_FOUR} op2_src_e;

	// encoding lines up with funct3[1:0] of the csr forms
	typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;

	typedef struct packed {
		logic     rs1_ren;
		logic     rs2_ren;
		logic     rd_wen;
		alu_op_e  alu_op;
		logic     op1_pc;
		op2_src_e op2_src;
		logic     branch;
		logic     jump;
		logic     jalr;
		csr_op_e  csr_op;
		logic     csr_imm;
		logic     csr_ren;
		logic     csr_wen;
		logic     illegal;
	} decode_ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [4:0]      rd;
		logic            we;
		logic [XLEN-1:0] data;
		logic            illegal;
	} retire_t;

endpackage

`default_nettype wire

/* sources.f */
rv_pkg.sv
id_stage.sv
regfile.sv
alu.sv
csr_file.sv
pc_unit.sv
core_top.sv
tb_core.sv

/* tb_core.sv */
// testbench for the rv64i execute slice, random instructions checked against an isa model
`timescale 1ns/1ps
`default_nettype none

module tb_core;

	logic                    clk;
	logic                    reset;
	logic                    inst_valid;
	logic [31:0]             inst;
	logic                    retire_valid;
	rv_pkg::retire_t         retire;
	logic [rv_pkg::XLEN-1:0] pc;

	// architectural state of the model
	logic [63:0] xreg [32];
	logic [63:0] m_pc;
	logic [63:0] m_mscratch;
	logic [63:0] m_mtvec;
	logic [63:0] m_mepc;

	core_top i_dut (.clk, .reset, .inst_valid, .inst, .retire_valid, .retire, .pc);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [63:0] sext32(input logic [31:0] v);
		return {{32{v[31]}}, v};
	endfunction

	function automatic logic [4:0] pick_reg();
		// mostly a small pool so results feed later instructions
		if ($urandom % 4 == 0) begin
			return 5'($urandom % 32);
		end
		return 5'($urandom % 8);
	endfunction

	function automatic logic [63:0] csr_read(input logic [11:0] addr);
		case (addr)
		rv_pkg::CSR_MSCRATCH: return m_mscratch;
		rv_pkg::CSR_MTVEC:    return m_mtvec;
		rv_pkg::CSR_MEPC:     return m_mepc;
		default:              return 64'd0;
		endcase
	endfunction

	task automatic csr_write(input logic [11:0] addr, input logic [63:0] v);
		case (addr)
		rv_pkg::CSR_MSCRATCH: m_mscratch = v;
		rv_pkg::CSR_MTVEC:    m_mtvec = v & ~64'h3;
		rv_pkg::CSR_MEPC:     m_mepc = v & ~64'h1;
		default:              m_mscratch = m_mscratch; // unknown csr, no effect
		endcase
	endtask

	function automatic logic [31:0] gen_inst();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [11:0] imm12;
		int k;
		r = $urandom;
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		f3 = 3'($urandom % 8);
		case ($urandom % 11)
		0: begin
			k = $urandom % 10;
			f7 = (k < 8) ? 7'h00 : 7'h20;
			f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
			return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
		end
		1, 2: begin
			imm12 = r[31:20];
			if (f3 == 3'd1) imm12[11:6] = 6'h00;
			if (f3 == 3'd5) imm12[11:6] = ($urandom % 2) ? 6'h10 : 6'h00;
			return {imm12, rs1, f3, rd, rv_pkg::OPC_IMM};
		end
		3: begin
			k = $urandom % 4;
			if (k == 0) return {r[31:20], rs1, 3'd0, rd, rv_pkg::OPC_IMM32};
			f7 = (k == 3) ? 7'h20 : 7'h00;
			f3 = (k == 1) ? 3'd1 : 3'd5;
			return {f7, r[24:20], rs1, f3, rd, rv_pkg::OPC_IMM32};
		end
		4: begin
			k = $urandom % 5;
			f7 = (k == 1 || k == 4) ? 7'h20 : 7'h00;
			f3 = (k < 2) ? 3'd0 : ((k == 2) ? 3'd1 : 3'd5);
			return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP32};
		end
		5: return {r[31:12], rd, rv_pkg::OPC_LUI};
		6: return {r[31:12], rd, rv_pkg::OPC_AUIPC};
		7: return {r[31:12], rd, rv_pkg::OPC_JAL};
		8: return {r[31:20], rs1, 3'd0, rd, rv_pkg::OPC_JALR};
		9: begin
			k = $urandom % 6;
			f3 = (k < 2) ? 3'(k) : 3'(k + 2);
			return {r[31:25], rs2, rs1, f3, r[11:7], rv_pkg::OPC_BRANCH};
		end
		default: begin
			k = $urandom % 6;
			f3 = (k < 3) ? 3'(k + 1) : 3'(k + 2); // the six csr forms
			case ($urandom % 4)
			0:       imm12 = rv_pkg::CSR_MSCRATCH;
			1:       imm12 = rv_pkg::CSR_MTVEC;
			2:       imm12 = rv_pkg::CSR_MEPC;
			default: imm12 = r[31:20];
			endcase
			return {imm12, rs1, f3, rd, rv_pkg::OPC_SYSTEM};
		end
		endcase
	endfunction

	// predicts the retire report and next pc, then updates the model state
	task automatic model_step(input logic [31:0] w, output rv_pkg::retire_t exp,
		output logic [63:0] npc);
		logic [2:0]  f3;
		logic [6:0]  f7;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] immi;
		logic [63:0] immb;
		logic [63:0] immu;
		logic [63:0] immj;
		logic [63:0] val;
		logic [63:0] src;
		logic [63:0] old;
		logic [63:0] nval;
		logic [31:0] w32;
		logic ill;
		logic wr;
		logic tk;
		f3 = w[14:12];
		f7 = w[31:25];
		rd = w[11:7];
		rs1 = w[19:15];
		a = xreg[rs1];
		b = xreg[w[24:20]];
		immi = {{52{w[31]}}, w[31:20]};
		immb = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		immu = {{32{w[31]}}, w[31:12], 12'h000};
		immj = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		ill = 1'b0;
		wr = 1'b1;
		tk = 1'b0;
		val = 64'd0;
		npc = m_pc + 64'd4;
		case (w[6:0])
		rv_pkg::OPC_LUI:   val = immu;
		rv_pkg::OPC_AUIPC: val = m_pc + immu;
		rv_pkg::OPC_JAL: begin
			val = m_pc + 64'd4;
			npc = m_pc + immj;
		end
		rv_pkg::OPC_JALR: begin
			ill = (f3 != 3'd0);
			val = m_pc + 64'd4;
			npc = (a + immi) & ~64'h1;
		end
		rv_pkg::OPC_BRANCH: begin
			wr = 1'b0;
			case (f3)
			3'd0:    tk = (a == b);
			3'd1:    tk = (a != b);
			3'd4:    tk = ($signed(a) < $signed(b));
			3'd5:    tk = ($signed(a) >= $signed(b));
			3'd6:    tk = (a < b);
			3'd7:    tk = (a >= b);
			default: ill = 1'b1;
			endcase
			if (tk) npc = m_pc + immb;
		end
		rv_pkg::OPC_IMM: begin
			case (f3)
			3'd0: val = a + immi;
			3'd1: begin
				ill = (w[31:26] != 6'h00);
				val = a << w[25:20];
			end
			3'd2: val = {63'd0, $signed(a) < $signed(immi)};
			3'd3: val = {63'd0, a < immi};
			3'd4: val = a ^ immi;
			3'd5: begin
				ill = (w[31:26] != 6'h00) && (w[31:26] != 6'h10);
				if (w[30]) begin
					val = $signed(a) >>> w[25:20];
				end else begin
					val = a >> w[25:20];
				end
			end
			3'd6: val = a | immi;
			default: val = a & immi;
			endcase
		end
		rv_pkg::OPC_IMM32: begin
			case (f3)
			3'd0: w32 = a[31:0] + immi[31:0];
			3'd1: begin
				ill = (f7 != 7'h00);
				w32 = a[31:0] << w[24:20];
			end
			3'd5: begin
				ill = (f7 != 7'h00) && (f7 != 7'h20);
				if (f7[5]) begin
					w32 = $signed(a[31:0]) >>> w[24:20];
				end else begin
					w32 = a[31:0] >> w[24:20];
				end
			end
			default: ill = 1'b1;
			endcase
			val = sext32(w32);
		end
		rv_pkg::OPC_OP: begin
			if (f7 == 7'h00) begin
				case (f3)
				3'd0: val = a + b;
				3'd1: val = a << b[5:0];
				3'd2: val = {63'd0, $signed(a) < $signed(b)};
				3'd3: val = {63'd0, a < b};
				3'd4: val = a ^ b;
				3'd5: val = a >> b[5:0];
				3'd6: val = a | b;
				default: val = a & b;
				endcase
			end else if (f7 == 7'h20 && f3 == 3'd0) begin
				val = a - b;
			end else if (f7 == 7'h20 && f3 == 3'd5) begin
				val = $signed(a) >>> b[5:0];
			end else begin
				ill = 1'b1;
			end
		end
		rv_pkg::OPC_OP32: begin
			case ({f7, f3})
			{7'h00, 3'd0}: w32 = a[31:0] + b[31:0];
			{7'h20, 3'd0}: w32 = a[31:0] - b[31:0];
			{7'h00, 3'd1}: w32 = a[31:0] << b[4:0];
			{7'h00, 3'd5}: w32 = a[31:0] >> b[4:0];
			{7'h20, 3'd5}: w32 = $signed(a[31:0]) >>> b[4:0];
			default:       ill = 1'b1;
			endcase
			val = sext32(w32);
		end
		rv_pkg::OPC_SYSTEM: begin
			if (f3 == 3'd0 || f3 == 3'd4) begin
				ill = 1'b1;
			end else begin
				src = f3[2] ? {59'd0, rs1} : a;
				old = csr_read(w[31:20]);
				val = (f3[1:0] == 2'b01 && rd == 5'd0) ? 64'd0 : old; // no read for csrrw to x0
				case (f3[1:0])
				2'b01:   nval = src;
				2'b10:   nval = old | src;
				default: nval = old & ~src;
				endcase
				if (f3[1:0] == 2'b01 || rs1 != 5'd0) csr_write(w[31:20], nval);
			end
		end
		default: ill = 1'b1;
		endcase
		if (ill) begin
			wr = 1'b0;
			npc = m_pc + 64'd4;
		end
		exp.pc = m_pc;
		exp.rd = rd;
		exp.we = wr;
		exp.data = val;
		exp.illegal = ill;
		if (wr && rd != 5'd0) xreg[rd] = val;
		m_pc = npc;
	endtask

	task automatic wait_retire(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			inst_valid = 1'b0;
			cycles++;
		end while (!retire_valid && cycles < 10);
		if (!retire_valid) begin
			$display("no retire arrived within %0d cycles of the instruction strobe", cycles);
			$display("=== FAIL ===");
			$fatal(1, "retire timeout");
		end
	endtask

	task automatic run_one(input logic [31:0] word, input int idx);
		rv_pkg::retire_t exp;
		logic [63:0] exp_pc;
		int cycles;
		inst = word;
		inst_valid = 1'b1;
		model_step(word, exp, exp_pc);
		wait_retire(cycles);
		check_value($sformatf("inst %0d (%h) latency", idx, word), 64'd1, 64'(cycles));
		check_value($sformatf("inst %0d (%h) retire pc", idx, word), exp.pc, retire.pc);
		check_value($sformatf("inst %0d (%h) illegal", idx, word), 64'(exp.illegal),
			64'(retire.illegal));
		check_value($sformatf("inst %0d (%h) we", idx, word), 64'(exp.we), 64'(retire.we));
		if (exp.we) begin
			check_value($sformatf("inst %0d (%h) rd", idx, word), 64'(exp.rd), 64'(retire.rd));
			check_value($sformatf("inst %0d (%h) data", idx, word), exp.data, retire.data);
		end
		check_value($sformatf("inst %0d (%h) next pc", idx, word), exp_pc, pc);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("idle retire_valid", 64'd0, 64'(retire_valid));
		end
	endtask

	initial begin
		logic [31:0] word;
		void'($urandom(32'h485d));
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		for (int i = 0; i < 32; i++) begin
			xreg[i] = 64'd0;
		end
		m_pc = 64'd0;
		m_mscratch = 64'd0;
		m_mtvec = 64'd0;
		m_mepc = 64'd0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("reset pc", 64'd0, pc);
		check_value("reset retire_valid", 64'd0, 64'(retire_valid));
		idle_cycles(4); // nothing retires before the first strobe
		for (int n = 0; n < 3000; n++) begin
			if ($urandom % 10 == 0) begin
				word = $urandom; // may still decode as legal
			end else begin
				word = gen_inst();
			end
			run_one(word, n);
			idle_cycles($urandom % 3);
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
